//--- src/datapath_defines.svh
// datapath size macros, included by the package and by any block that sizes by register count
`ifndef DATAPATH_DEFINES_SVH
`define DATAPATH_DEFINES_SVH

// word size of the bus, every register and the ALU
`define DATA_WIDTH 32

// general registers R0..R15, R0 is hardwired zero
`define REG_COUNT 16

`endif

//--- src/datapathPkg.sv
// shared datapath types, imported by the blocks that handle words, ALU ops or IR fields
`include "datapath_defines.svh"

package datapathPkg;

	typedef logic [`DATA_WIDTH-1:0] wordT;  // one bus word

	// ALU operation, a level held for the micro-step that raises zIn
	typedef enum logic [2:0] {
		opNone,
		opAnd,
		opOr,
		opNot,  // unary, bus only
		opAdd,
		opSub,  // Y minus bus
		opNeg,  // unary, bus only
		opShl   // Y shifted left by one
	} aluOpT;

	// which block owns the bus this cycle
	typedef enum logic [2:0] {
		srcNone,
		srcReg,
		srcPc,
		srcMdr,
		srcZLow
	} busSrcT;

	// three-register instruction format, msb first
	typedef struct packed {
		logic [4:0]  opcode;
		logic [3:0]  ra;    // destination
		logic [3:0]  rb;    // first source
		logic [3:0]  rc;    // second source
		logic [14:0] rest;  // unused in this format
	} instrFieldsT;

endpackage

//--- src/aluLink.sv
// operand and result group between the arithmetic unit, the logic unit and the result stage
`timescale 1ns/1ns

interface aluLink;
	import datapathPkg::*;

	wordT  yValue;       // Y register, first operand
	wordT  busValue;     // bus word this cycle, second operand
	aluOpT aluOp;        // op held by the control inputs
	wordT  arithResult;  // from arithUnit
	wordT  logicResult;  // from logicUnit

	// arithmetic side sees both operands
	modport arithPort (input yValue, busValue, aluOp, output arithResult);

	// logic side, same operands
	modport logicPort (input yValue, busValue, aluOp, output logicResult);

	// result stage only picks between the two results
	modport combinePort (input aluOp, arithResult, logicResult);

endinterface

//--- src/regFile.sv
// sixteen general registers, one of them picked by an IR field for bus load or bus drive
`timescale 1ns/1ns
`include "datapath_defines.svh"

module regFile (
	input  logic                     Clock,
	input  logic                     arstN,
	input  logic                     gra,       // select IR.ra
	input  logic                     grb,       // select IR.rb
	input  logic                     grc,       // select IR.rc
	input  logic                     rIn,
	input  logic                     rOut,
	input  datapathPkg::instrFieldsT irValue,
	input  datapathPkg::wordT        busValue,
	output datapathPkg::wordT        regValue,
	output logic                     regDrive
);
	import datapathPkg::*;

	localparam int IdxWidth = $clog2(`REG_COUNT);

	wordT                  regs [`REG_COUNT];
	logic [IdxWidth-1:0]   selIdx;     // register named by the chosen field
	logic [`REG_COUNT-1:0] selOneHot;  // decoded select, zero when no field chosen

	always_comb begin
		selIdx = '0;
		if (gra)
			selIdx = irValue.ra;
		else if (grb)
			selIdx = irValue.rb;
		else if (grc)
			selIdx = irValue.rc;
	end

	assign selOneHot = (gra | grb | grc) ? (`REG_COUNT'(1) << selIdx) : '0;

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (rIn) begin
			for (int i = 1; i < `REG_COUNT; i++) begin  // R0 never loads, stays zero
				if (selOneHot[i])
					regs[i] <= busValue;
			end
		end
	end

	// and-or read through the one-hot select
	always_comb begin
		regValue = '0;
		for (int i = 0; i < `REG_COUNT; i++) begin
			if (selOneHot[i])
				regValue = regValue | regs[i];
		end
	end

	assign regDrive = rOut;  // bus request to busEncoder

	// two field selects in one step would alias a load with a drive
	assert property (@(posedge Clock) disable iff (!arstN) $onehot0({gra, grb, grc}))
		else $error("regFile: more than one of gra, grb, grc high");

endmodule

//--- src/specialRegs.sv
// PC, IR, MAR, MDR and Y with their load rules, all loading at the rising edge
`timescale 1ns/1ns

module specialRegs (
	input  logic                     Clock,
	input  logic                     arstN,
	input  logic                     pcIn,
	input  logic                     incPc,
	input  logic                     irIn,
	input  logic                     marIn,
	input  logic                     mdrIn,
	input  logic                     read,      // MDR takes memory data, not the bus
	input  logic                     yIn,
	input  datapathPkg::wordT        busValue,
	input  datapathPkg::wordT        mDataIn,
	output datapathPkg::wordT        pcValue,
	output datapathPkg::instrFieldsT irValue,
	output datapathPkg::wordT        mdrValue,
	output datapathPkg::wordT        memAddress,  // MAR
	output datapathPkg::wordT        yValue       // first ALU operand
);
	import datapathPkg::*;

	wordT mdrNext;

	assign mdrNext = read ? mDataIn : busValue;  // memory read mux

	// PC, increment wins over a bus load
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN)
			pcValue <= '0;
		else if (incPc)
			pcValue <= pcValue + wordT'(4);
		else if (pcIn)
			pcValue <= busValue;
	end

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			irValue    <= '0;
			memAddress <= '0;
			mdrValue   <= '0;
			yValue     <= '0;
		end else begin
			if (irIn)
				irValue <= instrFieldsT'(busValue);
			if (marIn)
				memAddress <= busValue;
			if (mdrIn)
				mdrValue <= mdrNext;
			if (yIn)
				yValue <= busValue;  // held for the next ALU step
		end
	end

	// control sequences never ask for both, the loser would be silently lost
	assert property (@(posedge Clock) disable iff (!arstN) !(incPc && pcIn))
		else $error("specialRegs: incPc and pcIn high together");

endmodule

//--- src/arithUnit.sv
// arithmetic half of the ALU, add, subtract, negate and shift on Y and the bus
`timescale 1ns/1ns

module arithUnit (
	aluLink.arithPort alu
);
	import datapathPkg::*;

	always_comb begin
		case (alu.aluOp)
			opAdd:
				alu.arithResult = alu.yValue + alu.busValue;  // wraps at 32 bits
			opSub:
				alu.arithResult = alu.yValue - alu.busValue;
			opNeg:
				alu.arithResult = '0 - alu.busValue;  // two's complement of the bus
			opShl:
				alu.arithResult = alu.yValue << 1;
			default:
				alu.arithResult = '0;  // logic ops, result stage takes the other unit
		endcase
	end

endmodule

//--- src/logicUnit.sv
// logic half of the ALU, bitwise and, or, not
`timescale 1ns/1ns

module logicUnit (
	aluLink.logicPort alu
);
	import datapathPkg::*;

	always_comb begin
		case (alu.aluOp)
			opAnd:
				alu.logicResult = alu.yValue & alu.busValue;
			opOr:
				alu.logicResult = alu.yValue | alu.busValue;
			opNot:
				alu.logicResult = ~alu.busValue;  // Y not used
			default:
				alu.logicResult = '0;
		endcase
	end

endmodule

//--- src/resultCombine.sv
// picks the arithmetic or logic result for the current op and holds it in Z
`timescale 1ns/1ns

module resultCombine (
	input  logic              Clock,
	input  logic              arstN,
	input  logic              zIn,
	aluLink.combinePort       alu,
	output datapathPkg::wordT zLowValue
);
	import datapathPkg::*;

	logic isLogic;  // op belongs to logicUnit
	wordT zNext;

	assign isLogic = alu.aluOp inside {opAnd, opOr, opNot};
	assign zNext   = isLogic ? alu.logicResult : alu.arithResult;

	// Z low word, ready one edge after zIn
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN)
			zLowValue <= '0;
		else if (zIn)
			zLowValue <= zNext;
	end

	// a Z load with no op means the micro-step lost its ALU control
	assert property (@(posedge Clock) disable iff (!arstN) zIn |-> alu.aluOp != opNone)
		else $error("resultCombine: zIn with aluOp at opNone");

endmodule

//--- src/busEncoder.sv
// encodes the out-enables into one bus source and drives that word onto the shared bus
`timescale 1ns/1ns

module busEncoder (
	input  logic              Clock,  // only samples the enable check
	input  logic              arstN,
	input  logic              regDrive,
	input  logic              pcOut,
	input  logic              mdrOut,
	input  logic              zLowOut,
	input  datapathPkg::wordT regValue,
	input  datapathPkg::wordT pcValue,
	input  datapathPkg::wordT mdrValue,
	input  datapathPkg::wordT zLowValue,
	output datapathPkg::wordT busValue
);
	import datapathPkg::*;

	busSrcT busSrc;

	always_comb begin
		busSrc = srcNone;
		if (regDrive)
			busSrc = srcReg;
		else if (pcOut)
			busSrc = srcPc;
		else if (mdrOut)
			busSrc = srcMdr;
		else if (zLowOut)
			busSrc = srcZLow;
	end

	always_comb begin
		case (busSrc)
			srcReg:  busValue = regValue;
			srcPc:   busValue = pcValue;
			srcMdr:  busValue = mdrValue;
			srcZLow: busValue = zLowValue;
			default: busValue = '0;  // idle bus reads zero
		endcase
	end

	// enables come from four blocks' controls, two at once is a sequencing bug
	assert property (@(posedge Clock) disable iff (!arstN)
		$onehot0({regDrive, pcOut, mdrOut, zLowOut}))
		else $error("busEncoder: more than one bus source enabled");

endmodule

//--- src/cpuDatapath.sv
// single-bus datapath top, controls are levels from outside applied one micro-step per cycle
`timescale 1ns/1ns

module cpuDatapath (
	input  logic                 Clock,
	input  logic                 arstN,
	input  logic                 pcOut,
	input  logic                 zLowOut,
	input  logic                 mdrOut,
	input  logic                 rOut,
	input  logic                 gra,
	input  logic                 grb,
	input  logic                 grc,
	input  logic                 rIn,
	input  logic                 marIn,
	input  logic                 zIn,
	input  logic                 pcIn,
	input  logic                 mdrIn,
	input  logic                 irIn,
	input  logic                 yIn,
	input  logic                 incPc,
	input  logic                 read,
	input  datapathPkg::aluOpT   aluOp,
	input  datapathPkg::wordT    mDataIn,
	output datapathPkg::wordT    busData,
	output datapathPkg::wordT    memAddress
);
	import datapathPkg::*;

	wordT        regValue, pcValue, mdrValue, zLowValue, yValue;
	instrFieldsT irValue;
	logic        regDrive;

	aluLink alu ();

	// ALU operands, Y from specialRegs and the live bus
	assign alu.yValue   = yValue;
	assign alu.busValue = busData;
	assign alu.aluOp    = aluOp;

	regFile uRegFile (
		.Clock, .arstN, .gra, .grb, .grc, .rIn, .rOut,
		.irValue, .busValue(busData), .regValue, .regDrive
	);

	specialRegs uSpecialRegs (
		.Clock, .arstN, .pcIn, .incPc, .irIn, .marIn, .mdrIn, .read, .yIn,
		.busValue(busData), .mDataIn, .pcValue, .irValue, .mdrValue,
		.memAddress, .yValue
	);

	arithUnit uArithUnit (.alu(alu.arithPort));

	logicUnit uLogicUnit (.alu(alu.logicPort));

	resultCombine uResultCombine (.Clock, .arstN, .zIn, .alu(alu.combinePort), .zLowValue);

	busEncoder uBusEncoder (
		.Clock, .arstN, .regDrive, .pcOut, .mdrOut, .zLowOut,
		.regValue, .pcValue, .mdrValue, .zLowValue, .busValue(busData)
	);

endmodule

//--- verif/clockGen.sv
// testbench clock and power-on reset source, instantiated once by the datapath testbench
`timescale 1ns/1ns

module clockGen (
	output logic Clock,
	output logic arstN
);
	localparam int HalfPeriod  = 20;  // 40 ns period
	localparam int ResetCycles = 8;

	initial begin
		Clock = 1'b0;
		arstN = 1'b0;
		repeat (ResetCycles) @(posedge Clock);
		@(negedge Clock);
		arstN = 1'b1;  // released away from the rising edge
	end

	always #HalfPeriod Clock = ~Clock;

endmodule

//--- verif/cpuDatapathTb.sv
// directed testbench that drives datapath micro-steps and checks the bus and MAR
`timescale 1ns/1ns

module cpuDatapathTb;
	import datapathPkg::*;

	logic  Clock, arstN;
	logic  pcOut, zLowOut, mdrOut, rOut, gra, grb, grc, rIn;
	logic  marIn, zIn, pcIn, mdrIn, irIn, yIn, incPc, read;
	aluOpT aluOp;
	wordT  mDataIn, busData, memAddress;

	int          edgeCount = 0;          // rising edges seen so far
	logic [15:0] lfsrState = 16'd42890;  // operand source

	clockGen uClockGen (.Clock, .arstN);

	cpuDatapath DUT (.*);

	// nonblocking count lands after the pollers have looked at this edge
	always @(posedge Clock) edgeCount <= edgeCount + 1;

	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // galois form
	endfunction

	// one LFSR step per bit taken
	task automatic nextRandomWord(output wordT w);
		for (int i = 0; i < $bits(wordT); i++) begin
			w[i]      = lfsrState[0];
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	function automatic instrFieldsT makeInstr(input logic [4:0] opcode,
		input logic [3:0] ra, input logic [3:0] rb, input logic [3:0] rc);
		instrFieldsT f;
		f        = '0;
		f.opcode = opcode;
		f.ra     = ra;
		f.rb     = rb;
		f.rc     = rc;
		return f;
	endfunction

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compareWord(input string testName, input string what,
		input wordT expected, input wordT actual);
		if (actual !== expected)
			abortRun($sformatf("** Error [%s] %s: expected %h, actual %h",
				testName, what, expected, actual));
	endtask

	// returns 5 ns after the next rising edge
	task automatic waitRisingEdge(input string stepName);
		int startCount;
		int waited;
		startCount = edgeCount;
		waited     = 0;
		while (edgeCount == startCount) begin
			#1;
			waited++;
			if (waited > 100)
				abortRun($sformatf("timeout: clock stopped during %s", stepName));
		end
		#4;  // edge is seen 1 ns late
	endtask

	task automatic waitResetRelease();
		int waited;
		waited = 0;
		while (arstN !== 1'b1) begin
			#1;
			waited++;
			if (waited > 1000)
				abortRun("timeout: reset was never released");
		end
	endtask

	task automatic clearControls();
		{pcOut, zLowOut, mdrOut, rOut, gra, grb, grc, rIn} = '0;
		{marIn, zIn, pcIn, mdrIn, irIn, yIn, incPc, read}  = '0;
		aluOp   = opNone;
		mDataIn = '0;
	endtask

	task automatic endStep(input string stepName);
		waitRisingEdge(stepName);
		clearControls();
	endtask

	task automatic loadMdr(input wordT value);
		read    = 1'b1;  // memory side of the MDR mux
		mdrIn   = 1'b1;
		mDataIn = value;
		endStep("MDR load");
	endtask

	task automatic loadIr(input instrFieldsT ir);
		loadMdr(wordT'(ir));
		mdrOut = 1'b1;
		irIn   = 1'b1;
		endStep("IR load");
	endtask

	// IR.rc names the target
	task automatic writeReg(input logic [3:0] idx, input wordT value);
		loadIr(makeInstr(5'd0, 4'd0, 4'd0, idx));
		loadMdr(value);
		mdrOut = 1'b1;
		grc    = 1'b1;
		rIn    = 1'b1;
		endStep("register write");
	endtask

	task automatic checkReg(input string testName, input logic [3:0] idx, input wordT expected);
		loadIr(makeInstr(5'd0, 4'd0, 4'd0, idx));
		grc  = 1'b1;
		rOut = 1'b1;
		#10;  // bus has settled well clear of the edge
		compareWord(testName, $sformatf("R%0d", idx), expected, busData);
		endStep("register read");
	endtask

	// op R5, R2, R4 in four micro-steps after the operands are placed
	task automatic runAluOp(input string testName, input aluOpT op,
		input wordT a, input wordT b, input wordT expected);
		writeReg(4'd2, a);
		writeReg(4'd4, b);
		loadIr(makeInstr({2'b00, op}, 4'd5, 4'd2, 4'd4));
		grb  = 1'b1;
		rOut = 1'b1;
		yIn  = 1'b1;
		endStep("Y load");
		grc   = 1'b1;
		rOut  = 1'b1;
		aluOp = op;
		zIn   = 1'b1;
		endStep("Z load");
		zLowOut = 1'b1;
		gra     = 1'b1;
		rIn     = 1'b1;
		endStep("write-back");
		checkReg(testName, 4'd5, expected);
	endtask

	task automatic testReset();
		#30;  // mid reset
		compareWord("reset", "busData during reset", '0, busData);
		compareWord("reset", "memAddress during reset", '0, memAddress);
		waitResetRelease();
		waitRisingEdge("reset release");
		compareWord("reset", "busData after reset", '0, busData);
		compareWord("reset", "memAddress after reset", '0, memAddress);
	endtask

	task automatic testRegisterLoad();
		wordT v2, v4, v5, vZero;
		nextRandomWord(v2);
		nextRandomWord(v4);
		nextRandomWord(v5);
		nextRandomWord(vZero);
		writeReg(4'd2, v2);
		writeReg(4'd4, v4);
		writeReg(4'd5, v5);
		checkReg("register load", 4'd2, v2);
		checkReg("register load", 4'd4, v4);
		checkReg("register load", 4'd5, v5);
		writeReg(4'd0, vZero);  // ignored by R0
		checkReg("register load", 4'd0, '0);
	endtask

	task automatic testAndSequence();
		wordT a, b;
		nextRandomWord(a);
		nextRandomWord(b);
		runAluOp("and R5, R2, R4", opAnd, a, b, a & b);
	endtask

	task automatic testOtherOps();
		wordT a, b;
		nextRandomWord(a);
		nextRandomWord(b);
		runAluOp("or", opOr, a, b, a | b);
		runAluOp("not", opNot, a, b, ~b);  // bus operand only
		runAluOp("add", opAdd, a, b, a + b);
		runAluOp("add wrap", opAdd, 32'hFFFF_FFFF, 32'h0000_0002, 32'h0000_0001);
		runAluOp("sub", opSub, a, b, a + ~b + wordT'(1));  // Y plus two's complement of bus
		runAluOp("neg", opNeg, a, b, ~b + wordT'(1));
		runAluOp("shl", opShl, a, b, {a[30:0], 1'b0});
	endtask

	task automatic testPcAndMar();
		wordT target;
		incPc = 1'b1;  // PC 0 to 4
		endStep("PC increment");
		pcOut = 1'b1;
		marIn = 1'b1;
		#10;
		compareWord("pc and mar", "busData from PC", 32'd4, busData);
		endStep("MAR load");
		compareWord("pc and mar", "memAddress", 32'd4, memAddress);
		nextRandomWord(target);
		loadMdr(target);
		mdrOut = 1'b1;
		pcIn   = 1'b1;
		endStep("PC bus load");
		incPc = 1'b1;
		endStep("PC increment");
		pcOut = 1'b1;
		marIn = 1'b1;
		endStep("MAR load");
		compareWord("pc and mar", "memAddress after pcIn", target + 32'd4, memAddress);
	endtask

	initial begin
		clearControls();
		testReset();
		testRegisterLoad();
		testAndSequence();
		testOtherOps();
		testPcAndMar();
		$display("TEST OK");
		$finish;
	end

endmodule

//--- flist.f
+incdir+src
src/datapathPkg.sv
src/aluLink.sv
src/regFile.sv
src/specialRegs.sv
src/arithUnit.sv
src/logicUnit.sv
src/resultCombine.sv
src/busEncoder.sv
src/cpuDatapath.sv
verif/clockGen.sv
verif/cpuDatapathTb.sv

//--- Bender.yml
package:
  name: cpu_datapath

export_include_dirs:
  - src

sources:
  - files:
      - src/datapathPkg.sv
      - src/aluLink.sv
      - src/regFile.sv
      - src/specialRegs.sv
      - src/arithUnit.sv
      - src/logicUnit.sv
      - src/resultCombine.sv
      - src/busEncoder.sv
      - src/cpuDatapath.sv
  - target: test
    files:
      - verif/clockGen.sv
      - verif/cpuDatapathTb.sv
